// File: sim/rename_cases.txt
# dest_valid dest src1 src2 | exp_src1 exp_src2 exp_new exp_old  (decimal)
# ops without a destination expect zero new and old
1 1 2 3 2 3 32 1
1 2 1 1 32 32 33 2
1 3 1 2 32 33 34 3
0 0 3 4 34 4 0 0
1 1 1 3 32 34 35 32
1 4 5 6 5 6 36 4
1 5 4 1 36 35 37 5
1 6 7 8 7 8 38 6
1 7 6 5 38 37 39 7
1 8 9 10 9 10 40 8
1 9 8 2 40 33 41 9
1 10 11 12 11 12 42 10
0 0 9 10 41 42 0 0
1 11 10 9 42 41 43 11
1 12 13 14 13 14 44 12
1 13 12 11 44 43 45 13
1 14 15 16 15 16 46 14
1 15 14 13 46 45 47 15
1 16 17 18 17 18 48 16
1 17 16 15 48 47 49 17
1 18 19 20 19 20 50 18
1 19 18 17 50 49 51 19
1 20 21 22 21 22 52 20
1 21 20 19 52 51 53 21
1 22 23 24 23 24 54 22
1 23 22 21 54 53 55 23
1 24 25 26 25 26 56 24
1 25 24 23 56 55 57 25
1 26 27 28 27 28 58 26
1 1 1 26 35 58 59 35
1 27 0 31 0 31 60 27
0 0 1 27 59 60 0 0
1 28 29 30 29 30 61 28
1 2 2 28 33 61 62 33
1 3 3 2 34 62 63 34
1 1 1 3 59 63 1 59
1 4 1 4 1 36 2 36
0 0 4 1 2 1 0 0
1 29 4 29 2 29 3 29
1 30 29 3 3 63 32 30

// File: build.f
verilog/rename_pkg.sv
verilog/rename_intake.sv
verilog/rename_map_table.sv
verilog/free_list.sv
verilog/rename_core.sv
verilog/renamed_op_buffer.sv
verilog/rename_unit.sv
sim/rename_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the rename stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module rename_unit_tb -o rename_unit_tb \
    && ./obj_dir/rename_unit_tb \
    || { echo "simulation failed"; exit 1; }

// File: sim/rename_unit_tb.sv
/*
 * rename stage testbench
 * replays ops from a case file through the credit-fed front end,
 * returns issue credits after random delays, commits old registers
 * and compares every renamed op with its expected fields
 */
`timescale 1ns/1ps
`default_nettype none

module rename_unit_tb;

    localparam int MAX_CASES     = 64;
    localparam int CYCLES_PER_OP = 20;
    // cycles of enforced free-list starvation before commits start
    localparam int DRY_CYCLES    = 8;
    localparam int DRIVE_DELAY   = 2;

    logic                  clock;
    logic                  reset;
    logic                  in_valid;
    logic                  in_dest_valid;
    rename_pkg::arch_reg_t in_dest;
    rename_pkg::arch_reg_t in_src1;
    rename_pkg::arch_reg_t in_src2;
    logic                  in_credit;
    logic                  commit_valid;
    rename_pkg::phys_reg_t commit_phys;
    logic                  issue_credit;
    logic                  out_valid;
    logic                  out_dest_valid;
    rename_pkg::phys_reg_t out_new_phys;
    rename_pkg::phys_reg_t out_old_phys;
    rename_pkg::phys_reg_t out_src1_phys;
    rename_pkg::phys_reg_t out_src2_phys;

    // ==================================================
    // case table
    // ==================================================
    logic                  case_dv   [MAX_CASES];
    rename_pkg::arch_reg_t case_dest [MAX_CASES];
    rename_pkg::arch_reg_t case_src1 [MAX_CASES];
    rename_pkg::arch_reg_t case_src2 [MAX_CASES];
    rename_pkg::phys_reg_t exp_src1  [MAX_CASES];
    rename_pkg::phys_reg_t exp_src2  [MAX_CASES];
    rename_pkg::phys_reg_t exp_new   [MAX_CASES];
    rename_pkg::phys_reg_t exp_old   [MAX_CASES];
    int                    n_cases;
    // first op that needs a recycled register
    int                    dry_idx;

    rename_unit u_rename_unit (
        .clock            (clock),
        .reset            (reset),
        .in_valid_i       (in_valid),
        .in_dest_valid_i  (in_dest_valid),
        .in_dest_i        (in_dest),
        .in_src1_i        (in_src1),
        .in_src2_i        (in_src2),
        .in_credit_o      (in_credit),
        .commit_valid_i   (commit_valid),
        .commit_phys_i    (commit_phys),
        .issue_credit_i   (issue_credit),
        .out_valid_o      (out_valid),
        .out_dest_valid_o (out_dest_valid),
        .out_new_phys_o   (out_new_phys),
        .out_old_phys_o   (out_old_phys),
        .out_src1_phys_o  (out_src1_phys),
        .out_src2_phys_o  (out_src2_phys)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    task automatic check_phys(input string field, input rename_pkg::phys_reg_t got,
                              input rename_pkg::phys_reg_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s: got %0d expected %0d", $time, field, got, exp);
            $display("TEST FAILED");
            $fatal(1, "physical register mismatch");
        end
    endtask

    task automatic check_flag(input string field, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s: got %0b expected %0b", $time, field, got, exp);
            $display("TEST FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    // all fields of one issued op
    task automatic verify_op(input int idx);
        check_flag($sformatf("op %0d dest_valid", idx), out_dest_valid, case_dv[idx]);
        check_phys($sformatf("op %0d src1_phys", idx), out_src1_phys, exp_src1[idx]);
        check_phys($sformatf("op %0d src2_phys", idx), out_src2_phys, exp_src2[idx]);
        check_phys($sformatf("op %0d new_phys", idx), out_new_phys, exp_new[idx]);
        check_phys($sformatf("op %0d old_phys", idx), out_old_phys, exp_old[idx]);
    endtask

    task automatic load_cases();
        int    fd;
        int    code;
        int    dests;
        int    dv, dst, s1, s2, e1, e2, en, eo;
        string line;
        fd = $fopen("sim/rename_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file sim/rename_cases.txt");
            $display("TEST FAILED");
            $fatal(1, "missing case file");
        end else begin
            n_cases = 0;
            dests   = 0;
            dry_idx = -1;
            while (!$feof(fd) && n_cases < MAX_CASES) begin
                code = $fgets(line, fd);
                // skip comment and blank lines
                if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    code = $sscanf(line, "%d %d %d %d %d %d %d %d",
                                   dv, dst, s1, s2, e1, e2, en, eo);
                    if (code == 8) begin
                        case_dv[n_cases]   = (dv != 0);
                        case_dest[n_cases] = rename_pkg::arch_reg_t'(dst);
                        case_src1[n_cases] = rename_pkg::arch_reg_t'(s1);
                        case_src2[n_cases] = rename_pkg::arch_reg_t'(s2);
                        exp_src1[n_cases]  = rename_pkg::phys_reg_t'(e1);
                        exp_src2[n_cases]  = rename_pkg::phys_reg_t'(e2);
                        exp_new[n_cases]   = rename_pkg::phys_reg_t'(en);
                        exp_old[n_cases]   = rename_pkg::phys_reg_t'(eo);
                        if (dv != 0) begin
                            dests++;
                            if (dests == rename_pkg::FREE_REGS + 1) begin
                                dry_idx = n_cases;
                            end
                        end
                        n_cases++;
                    end
                end
            end
            $fclose(fd);
            // too few writers to drain the free list
            if (dry_idx < 0) begin
                dry_idx = n_cases;
            end
        end
    endtask

    // ==================================================
    // producer, consumer and commit model
    // ==================================================
    initial begin : stimulus
        int                    seed;
        int                    cycle;
        int                    limit;
        int                    next_send;
        int                    checked;
        int                    credits;
        int                    credit_pulses;
        int                    returned;
        int                    received;
        int                    dry_count;
        logic                  commit_open;
        logic                  resume_due;
        int                    return_due [$];
        rename_pkg::phys_reg_t commit_q   [$];

        reset         = 1'b1;
        in_valid      = 1'b0;
        in_dest_valid = 1'b0;
        in_dest       = '0;
        in_src1       = '0;
        in_src2       = '0;
        commit_valid  = 1'b0;
        commit_phys   = '0;
        issue_credit  = 1'b0;
        seed          = 32'h99b3;
        cycle         = 0;
        next_send     = 0;
        checked       = 0;
        credits       = rename_pkg::INTAKE_DEPTH;
        credit_pulses = 0;
        returned      = 0;
        received      = 0;
        dry_count     = 0;
        commit_open   = 1'b0;
        resume_due    = 1'b0;

        load_cases();
        limit = n_cases * CYCLES_PER_OP;

        repeat (10) @(posedge clock);
        #DRIVE_DELAY reset = 1'b0;

        while (checked < n_cases && cycle < limit) begin
            @(posedge clock);
            #DRIVE_DELAY;
            cycle++;

            // front-end credit back
            if (in_credit) begin
                credits++;
                credit_pulses++;
            end
            check_flag("front-end credit bound", credits <= rename_pkg::INTAKE_DEPTH, 1'b1);

            // starved free list, nothing may issue
            if (!commit_open && checked == dry_idx) begin
                check_flag("out_valid_o while free list empty", out_valid, 1'b0);
                dry_count++;
                if (dry_count == DRY_CYCLES) begin
                    commit_open = 1'b1;
                end
            end
            // stalled op goes the edge after the first commit
            if (resume_due) begin
                check_flag("out_valid_o after first commit", out_valid, 1'b1);
                resume_due = 1'b0;
            end

            if (out_valid) begin
                verify_op(checked);
                received++;
                check_flag("issue credit bound",
                           received <= returned + rename_pkg::ISSUE_CREDITS, 1'b1);
                return_due.push_back(cycle + ($random(seed) & 3));
                if (case_dv[checked]) begin
                    commit_q.push_back(exp_old[checked]);
                end
                checked++;
            end

            // next op while a credit is held
            if (credits > 0 && next_send < n_cases) begin
                in_valid      = 1'b1;
                in_dest_valid = case_dv[next_send];
                in_dest       = case_dest[next_send];
                in_src1       = case_src1[next_send];
                in_src2       = case_src2[next_send];
                credits--;
                next_send++;
            end else begin
                in_valid = 1'b0;
            end

            // one issue credit per cycle at most
            if (return_due.size() > 0 && return_due[0] <= cycle) begin
                issue_credit = 1'b1;
                void'(return_due.pop_front());
                returned++;
            end else begin
                issue_credit = 1'b0;
            end

            // commits in program order, some cycles skipped
            if (commit_open && commit_q.size() > 0 && ($random(seed) & 3) != 0) begin
                commit_valid = 1'b1;
                commit_phys  = commit_q.pop_front();
                if (checked == dry_idx && dry_count == DRY_CYCLES) begin
                    resume_due = 1'b1;
                    dry_count++;
                end
            end else begin
                commit_valid = 1'b0;
            end
        end

        if (checked < n_cases) begin
            $display("timeout: %0d of %0d ops issued after %0d cycles", checked, n_cases, cycle);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end else begin
            check_flag("in_credit_o pulse total", credit_pulses == n_cases, 1'b1);
            $display("TEST OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rename_unit.sv
/*
 * rename stage top
 * intake queue, rename core and renamed op buffer in a row
 */
`timescale 1ns/1ps
`default_nettype none

module rename_unit (
    input  logic                  clock,
    input  logic                  reset,
    // front end
    input  logic                  in_valid_i,
    input  logic                  in_dest_valid_i,
    input  rename_pkg::arch_reg_t in_dest_i,
    input  rename_pkg::arch_reg_t in_src1_i,
    input  rename_pkg::arch_reg_t in_src2_i,
    output logic                  in_credit_o,
    // commit
    input  logic                  commit_valid_i,
    input  rename_pkg::phys_reg_t commit_phys_i,
    // issue
    input  logic                  issue_credit_i,
    output logic                  out_valid_o,
    output logic                  out_dest_valid_o,
    output rename_pkg::phys_reg_t out_new_phys_o,
    output rename_pkg::phys_reg_t out_old_phys_o,
    output rename_pkg::phys_reg_t out_src1_phys_o,
    output rename_pkg::phys_reg_t out_src2_phys_o
);

    // intake head
    logic                  head_valid;
    logic                  head_dest_valid;
    rename_pkg::arch_reg_t head_dest;
    rename_pkg::arch_reg_t head_src1;
    rename_pkg::arch_reg_t head_src2;
    logic                  head_pop;

    // core to buffer
    logic                  has_room;
    logic                  push;
    logic                  push_dest_valid;
    rename_pkg::phys_reg_t push_new_phys;
    rename_pkg::phys_reg_t push_old_phys;
    rename_pkg::phys_reg_t push_src1_phys;
    rename_pkg::phys_reg_t push_src2_phys;

    rename_intake u_intake (
        .clock             (clock),
        .reset             (reset),
        .in_valid_i        (in_valid_i),
        .in_dest_valid_i   (in_dest_valid_i),
        .in_dest_i         (in_dest_i),
        .in_src1_i         (in_src1_i),
        .in_src2_i         (in_src2_i),
        .head_pop_i        (head_pop),
        .in_credit_o       (in_credit_o),
        .head_valid_o      (head_valid),
        .head_dest_valid_o (head_dest_valid),
        .head_dest_o       (head_dest),
        .head_src1_o       (head_src1),
        .head_src2_o       (head_src2)
    );

    rename_core u_core (
        .clock             (clock),
        .reset             (reset),
        .head_valid_i      (head_valid),
        .head_dest_valid_i (head_dest_valid),
        .head_dest_i       (head_dest),
        .head_src1_i       (head_src1),
        .head_src2_i       (head_src2),
        .release_valid_i   (commit_valid_i),
        .release_phys_i    (commit_phys_i),
        .has_room_i        (has_room),
        .head_pop_o        (head_pop),
        .push_o            (push),
        .push_dest_valid_o (push_dest_valid),
        .push_new_phys_o   (push_new_phys),
        .push_old_phys_o   (push_old_phys),
        .push_src1_phys_o  (push_src1_phys),
        .push_src2_phys_o  (push_src2_phys)
    );

    renamed_op_buffer u_out_buffer (
        .clock             (clock),
        .reset             (reset),
        .push_i            (push),
        .push_dest_valid_i (push_dest_valid),
        .push_new_phys_i   (push_new_phys),
        .push_old_phys_i   (push_old_phys),
        .push_src1_phys_i  (push_src1_phys),
        .push_src2_phys_i  (push_src2_phys),
        .issue_credit_i    (issue_credit_i),
        .has_room_o        (has_room),
        .out_valid_o       (out_valid_o),
        .out_dest_valid_o  (out_dest_valid_o),
        .out_new_phys_o    (out_new_phys_o),
        .out_old_phys_o    (out_old_phys_o),
        .out_src1_phys_o   (out_src1_phys_o),
        .out_src2_phys_o   (out_src2_phys_o)
    );

endmodule

`default_nettype wire

// File: verilog/renamed_op_buffer.sv
/*
 * renamed op buffer
 * four-entry output queue toward issue, sends only while
 * issue credits remain, one credit spent per op sent
 */
`timescale 1ns/1ps
`default_nettype none

module renamed_op_buffer (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  push_i,
    input  logic                  push_dest_valid_i,
    input  rename_pkg::phys_reg_t push_new_phys_i,
    input  rename_pkg::phys_reg_t push_old_phys_i,
    input  rename_pkg::phys_reg_t push_src1_phys_i,
    input  rename_pkg::phys_reg_t push_src2_phys_i,
    input  logic                  issue_credit_i,
    output logic                  has_room_o,
    output logic                  out_valid_o,
    output logic                  out_dest_valid_o,
    output rename_pkg::phys_reg_t out_new_phys_o,
    output rename_pkg::phys_reg_t out_old_phys_o,
    output rename_pkg::phys_reg_t out_src1_phys_o,
    output rename_pkg::phys_reg_t out_src2_phys_o
);

    logic                  dest_valid_q [rename_pkg::OUT_DEPTH];
    rename_pkg::phys_reg_t new_q        [rename_pkg::OUT_DEPTH];
    rename_pkg::phys_reg_t old_q        [rename_pkg::OUT_DEPTH];
    rename_pkg::phys_reg_t src1_q       [rename_pkg::OUT_DEPTH];
    rename_pkg::phys_reg_t src2_q       [rename_pkg::OUT_DEPTH];

    logic [$clog2(rename_pkg::OUT_DEPTH)-1:0] head_ptr;
    logic [$clog2(rename_pkg::OUT_DEPTH)-1:0] tail_ptr;
    logic [$clog2(rename_pkg::OUT_DEPTH):0]   count;
    rename_pkg::credit_t                      credit;

    logic send;
    logic bypass;
    logic do_write;
    logic do_read;

    // ==================================================
    // send decision
    // ==================================================
    assign has_room_o = (count < rename_pkg::OUT_DEPTH);
    assign send       = (credit != '0) && ((count != '0) || push_i);
    // incoming op goes straight to the output when the queue is empty
    assign bypass     = send && (count == '0);
    assign do_write   = push_i && !bypass;
    assign do_read    = send && (count != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr    <= '0;
            tail_ptr    <= '0;
            count       <= '0;
            credit      <= rename_pkg::credit_t'(rename_pkg::ISSUE_CREDITS);
            out_valid_o <= 1'b0;
        end else begin
            if (do_write) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (do_read) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (do_write && !do_read) begin
                count <= count + 1'b1;
            end else if (do_read && !do_write) begin
                count <= count - 1'b1;
            end
            // one credit spent per send and one back per return
            if (send && !issue_credit_i) begin
                credit <= credit - 1'b1;
            end else if (issue_credit_i && !send) begin
                credit <= credit + 1'b1;
            end
            out_valid_o <= send;
        end
    end

    // queue storage and output fields
    always_ff @(posedge clock) begin
        if (do_write) begin
            dest_valid_q[tail_ptr] <= push_dest_valid_i;
            new_q[tail_ptr]        <= push_new_phys_i;
            old_q[tail_ptr]        <= push_old_phys_i;
            src1_q[tail_ptr]       <= push_src1_phys_i;
            src2_q[tail_ptr]       <= push_src2_phys_i;
        end
        if (bypass) begin
            out_dest_valid_o <= push_dest_valid_i;
            out_new_phys_o   <= push_new_phys_i;
            out_old_phys_o   <= push_old_phys_i;
            out_src1_phys_o  <= push_src1_phys_i;
            out_src2_phys_o  <= push_src2_phys_i;
        end else if (do_read) begin
            out_dest_valid_o <= dest_valid_q[head_ptr];
            out_new_phys_o   <= new_q[head_ptr];
            out_old_phys_o   <= old_q[head_ptr];
            out_src1_phys_o  <= src1_q[head_ptr];
            out_src2_phys_o  <= src2_q[head_ptr];
        end
    end

    // consumer returned more than it was given
    a_credit_max: assert property (@(posedge clock) disable iff (reset)
        credit <= rename_pkg::credit_t'(rename_pkg::ISSUE_CREDITS))
        else $error("issue credit overflow");

endmodule

`default_nettype wire

// File: verilog/rename_core.sv
/*
 * rename core
 * decides when the head op renames, reads and updates the map,
 * allocates from the free list and pushes the renamed op
 */
`timescale 1ns/1ps
`default_nettype none

module rename_core (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  head_valid_i,
    input  logic                  head_dest_valid_i,
    input  rename_pkg::arch_reg_t head_dest_i,
    input  rename_pkg::arch_reg_t head_src1_i,
    input  rename_pkg::arch_reg_t head_src2_i,
    input  logic                  release_valid_i,
    input  rename_pkg::phys_reg_t release_phys_i,
    input  logic                  has_room_i,
    output logic                  head_pop_o,
    output logic                  push_o,
    output logic                  push_dest_valid_o,
    output rename_pkg::phys_reg_t push_new_phys_o,
    output rename_pkg::phys_reg_t push_old_phys_o,
    output rename_pkg::phys_reg_t push_src1_phys_o,
    output rename_pkg::phys_reg_t push_src2_phys_o
);

    rename_pkg::phys_reg_t   old_phys;
    rename_pkg::phys_reg_t   alloc_phys;
    logic                    alloc_valid;
    logic                    alloc_req;
    logic                    fire;
    rename_pkg::free_count_t free_count;
    rename_pkg::core_state_e state_q;
    rename_pkg::core_state_e state_d;

    // ==================================================
    // fire decision
    // ==================================================
    // a register is only needed for ops that write
    assign fire      = head_valid_i && has_room_i && (!head_dest_valid_i || alloc_valid);
    assign alloc_req = fire && head_dest_valid_i;

    assign head_pop_o        = fire;
    assign push_o            = fire;
    assign push_dest_valid_o = head_dest_valid_i;
    // no destination, zero new and old
    assign push_new_phys_o   = head_dest_valid_i ? alloc_phys : '0;
    assign push_old_phys_o   = head_dest_valid_i ? old_phys : '0;

    rename_map_table u_map_table (
        .clock        (clock),
        .reset        (reset),
        .src1_i       (head_src1_i),
        .src2_i       (head_src2_i),
        .dest_i       (head_dest_i),
        .write_i      (alloc_req),
        .write_phys_i (alloc_phys),
        .src1_phys_o  (push_src1_phys_o),
        .src2_phys_o  (push_src2_phys_o),
        .old_phys_o   (old_phys)
    );

    // commit releases go straight in
    free_list u_free_list (
        .clock           (clock),
        .reset           (reset),
        .alloc_req_i     (alloc_req),
        .release_valid_i (release_valid_i),
        .release_phys_i  (release_phys_i),
        .alloc_phys_o    (alloc_phys),
        .alloc_valid_o   (alloc_valid),
        .free_count_o    (free_count)
    );

    // ==================================================
    // state tracking
    // ==================================================
    always_comb begin
        if (!head_valid_i) begin
            state_d = rename_pkg::RN_IDLE;
        end else if (!has_room_i) begin
            state_d = rename_pkg::RN_STALL_OUT;
        end else if (head_dest_valid_i && free_count == '0 && !release_valid_i) begin
            state_d = rename_pkg::RN_STALL_FREE;
        end else begin
            state_d = rename_pkg::RN_RENAME;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state_q <= rename_pkg::RN_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a free-list stall is only broken by a commit
    a_stall_free_exit: assert property (@(posedge clock) disable iff (reset)
        (state_q == rename_pkg::RN_STALL_FREE && state_d == rename_pkg::RN_RENAME)
        |-> release_valid_i)
        else $error("free stall left without a release");

endmodule

`default_nettype wire

// File: verilog/free_list.sv
/*
 * physical register free list
 * circular queue of free registers, release-first:
 * a register released this cycle can be allocated this cycle
 */
`timescale 1ns/1ps
`default_nettype none

module free_list (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    alloc_req_i,
    input  logic                    release_valid_i,
    input  rename_pkg::phys_reg_t   release_phys_i,
    output rename_pkg::phys_reg_t   alloc_phys_o,
    output logic                    alloc_valid_o,
    output rename_pkg::free_count_t free_count_o
);

    rename_pkg::phys_reg_t fifo_q [rename_pkg::FREE_REGS];

    // 32 entries, pointers wrap naturally
    logic [$clog2(rename_pkg::FREE_REGS)-1:0] head_ptr;
    logic [$clog2(rename_pkg::FREE_REGS)-1:0] tail_ptr;
    rename_pkg::free_count_t                  count;

    logic is_empty;
    logic bypass;
    logic do_push;
    logic do_pop;

    // ==================================================
    // allocate side
    // ==================================================
    assign is_empty = (count == '0);
    // empty queue, released register goes straight out
    assign bypass   = is_empty && release_valid_i;

    assign alloc_valid_o = !is_empty || release_valid_i;
    assign alloc_phys_o  = bypass ? release_phys_i : fifo_q[head_ptr];
    assign free_count_o  = count;

    // bypassed release never enters the queue
    assign do_pop  = alloc_req_i && !is_empty;
    assign do_push = release_valid_i && !(bypass && alloc_req_i);

    // ==================================================
    // queue state
    // ==================================================
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr <= '0;
            // full queue, tail meets head
            tail_ptr <= '0;
            count    <= rename_pkg::free_count_t'(rename_pkg::FREE_REGS);
        end else begin
            if (do_pop) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (do_push) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            // releases minus allocations
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // storage, starts as 32..63 in order
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::FREE_REGS; i++) begin
                fifo_q[i] <= rename_pkg::phys_reg_t'(rename_pkg::ARCH_REGS + i);
            end
        end else if (do_push) begin
            fifo_q[tail_ptr] <= release_phys_i;
        end
    end

    // releasing a register that was never allocated
    a_count_max: assert property (@(posedge clock) disable iff (reset)
        count <= rename_pkg::free_count_t'(rename_pkg::FREE_REGS))
        else $error("free list count over capacity");

    // core must only request when a register is there
    a_alloc_valid: assert property (@(posedge clock) disable iff (reset)
        alloc_req_i |-> alloc_valid_o)
        else $error("allocation with no free register");

endmodule

`default_nettype wire

// File: verilog/rename_map_table.sv
/*
 * register map table
 * architectural to physical map, identity after reset,
 * three combinational reads and one write per cycle
 */
`timescale 1ns/1ps
`default_nettype none

module rename_map_table (
    input  logic                  clock,
    input  logic                  reset,
    input  rename_pkg::arch_reg_t src1_i,
    input  rename_pkg::arch_reg_t src2_i,
    input  rename_pkg::arch_reg_t dest_i,
    input  logic                  write_i,
    input  rename_pkg::phys_reg_t write_phys_i,
    output rename_pkg::phys_reg_t src1_phys_o,
    output rename_pkg::phys_reg_t src2_phys_o,
    output rename_pkg::phys_reg_t old_phys_o
);

    rename_pkg::phys_reg_t map_q [rename_pkg::ARCH_REGS];

    // reads see the mapping from before this cycle's write
    assign src1_phys_o = map_q[src1_i];
    assign src2_phys_o = map_q[src2_i];
    assign old_phys_o  = map_q[dest_i];

    always_ff @(posedge clock) begin
        if (reset) begin
            // arch i starts on phys i
            for (int i = 0; i < rename_pkg::ARCH_REGS; i++) begin
                map_q[i] <= rename_pkg::phys_reg_t'(i);
            end
        end else if (write_i) begin
            map_q[dest_i] <= write_phys_i;
        end
    end

endmodule

`default_nettype wire

// File: verilog/rename_intake.sv
/*
 * rename intake queue
 * four-entry FIFO of decoded ops fed by front-end credits,
 * one credit pulse returned for every op that leaves
 */
`timescale 1ns/1ps
`default_nettype none

module rename_intake (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  in_valid_i,
    input  logic                  in_dest_valid_i,
    input  rename_pkg::arch_reg_t in_dest_i,
    input  rename_pkg::arch_reg_t in_src1_i,
    input  rename_pkg::arch_reg_t in_src2_i,
    input  logic                  head_pop_i,
    output logic                  in_credit_o,
    output logic                  head_valid_o,
    output logic                  head_dest_valid_o,
    output rename_pkg::arch_reg_t head_dest_o,
    output rename_pkg::arch_reg_t head_src1_o,
    output rename_pkg::arch_reg_t head_src2_o
);

    // op storage
    logic                  dest_valid_q [rename_pkg::INTAKE_DEPTH];
    rename_pkg::arch_reg_t dest_q       [rename_pkg::INTAKE_DEPTH];
    rename_pkg::arch_reg_t src1_q       [rename_pkg::INTAKE_DEPTH];
    rename_pkg::arch_reg_t src2_q       [rename_pkg::INTAKE_DEPTH];

    // pointers wrap on their own, depth is a power of two
    logic [$clog2(rename_pkg::INTAKE_DEPTH)-1:0] head_ptr;
    logic [$clog2(rename_pkg::INTAKE_DEPTH)-1:0] tail_ptr;
    logic [$clog2(rename_pkg::INTAKE_DEPTH):0]   count;

    assign head_valid_o      = (count != '0);
    assign head_dest_valid_o = dest_valid_q[head_ptr];
    assign head_dest_o       = dest_q[head_ptr];
    assign head_src1_o       = src1_q[head_ptr];
    assign head_src2_o       = src2_q[head_ptr];

    // control state
    always_ff @(posedge clock) begin
        if (reset) begin
            head_ptr    <= '0;
            tail_ptr    <= '0;
            count       <= '0;
            in_credit_o <= 1'b0;
        end else begin
            if (in_valid_i) begin
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (head_pop_i) begin
                head_ptr <= head_ptr + 1'b1;
            end
            if (in_valid_i && !head_pop_i) begin
                count <= count + 1'b1;
            end else if (head_pop_i && !in_valid_i) begin
                count <= count - 1'b1;
            end
            // credit goes back the cycle after the pop
            in_credit_o <= head_pop_i;
        end
    end

    // payload write at tail
    always_ff @(posedge clock) begin
        if (in_valid_i) begin
            dest_valid_q[tail_ptr] <= in_dest_valid_i;
            dest_q[tail_ptr]       <= in_dest_i;
            src1_q[tail_ptr]       <= in_src1_i;
            src2_q[tail_ptr]       <= in_src2_i;
        end
    end

    // sender pushed without holding a credit
    a_no_push_full: assert property (@(posedge clock) disable iff (reset)
        in_valid_i |-> (count != rename_pkg::INTAKE_DEPTH))
        else $error("intake push while full");

endmodule

`default_nettype wire

// File: verilog/rename_pkg.sv
/*
 * rename stage shared definitions
 * register counts, queue depths, credit counts,
 * vector typedefs and the rename core FSM states
 */
`default_nettype none

package rename_pkg;

    // ==================================================
    // sizes
    // ==================================================
    localparam int ARCH_REGS     = 32;
    localparam int PHYS_REGS     = 64;
    // only the non-initial registers start out free
    localparam int FREE_REGS     = PHYS_REGS - ARCH_REGS;
    localparam int INTAKE_DEPTH  = 4;
    localparam int OUT_DEPTH     = 4;
    localparam int ISSUE_CREDITS = 4;

    // ==================================================
    // types
    // ==================================================
    typedef logic [4:0] arch_reg_t;
    typedef logic [5:0] phys_reg_t;
    // 0 to 32 inclusive
    typedef logic [5:0] free_count_t;
    typedef logic [2:0] credit_t;

    // rename core states
    typedef enum logic [1:0] {
        RN_IDLE,
        RN_RENAME,
        RN_STALL_FREE,
        RN_STALL_OUT
    } core_state_e;

endpackage

`default_nettype wire
